// ==== Makefile ====
# Verilator build and run for the RV32I core testbench

TOP       ?= tb_core
SEED      ?= 0
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee /dev/stderr | grep -qF "PASS: all tests"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/core_checker.sv ====
// Result checker for the core testbench
// Watches the data memory port, checks store lanes and the sentinel word

`timescale 1ns/10ps

module core_checker #(
    parameter core_pkg::xlen_t RESET_PC      = '0,
    parameter core_pkg::xlen_t SENTINEL_ADDR = 32'h0000_0100
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  core_pkg::xlen_t    instruction_address_i,
    input  core_pkg::xlen_t    mem_address_i,
    input  core_pkg::xlen_t    mem_data_i,
    input  core_pkg::byte_en_t mem_write_enable_i,
    input  logic               mem_operation_enable_i,
    input  logic               compare_i,
    input  core_pkg::xlen_t    expected_i,
    output logic               sentinel_seen_o,
    output int                 error_count_o
);

    core_pkg::xlen_t sentinel_data;

    // Byte, aligned halfword or aligned word at the given offset
    function automatic logic lanes_ok(logic [1:0] a, core_pkg::byte_en_t we);
        case (we)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return we == (4'b0001 << a);
            4'b0011, 4'b1100:                   return we == (4'b0011 << a);
            4'b1111:                            return a == 2'b00;
            default:                            return 1'b0;
        endcase
    endfunction

    // First full-word store to the sentinel wins
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sentinel_seen_o <= 1'b0;
            sentinel_data   <= '0;
        end else if (!sentinel_seen_o && mem_operation_enable_i
                     && mem_write_enable_i == 4'b1111 && mem_address_i == SENTINEL_ADDR) begin
            sentinel_seen_o <= 1'b1;
            sentinel_data   <= mem_data_i;
        end
    end

    initial error_count_o = 0;

    always @(posedge clk) begin
        if (!rst_n_i) begin
            // Idle bus and PC at its start while in reset
            if (mem_operation_enable_i || instruction_address_i != RESET_PC) begin
                $display("FAILED at %0t: reset state, enable %b, address %h, expected PC %h",
                         $time, mem_operation_enable_i, instruction_address_i, RESET_PC);
                error_count_o <= error_count_o + 1;
            end
        end else begin
            if (mem_operation_enable_i && mem_write_enable_i != '0
                && !lanes_ok(mem_address_i[1:0], mem_write_enable_i)) begin
                $display("FAILED at %0t: lanes %b do not match address %h",
                         $time, mem_write_enable_i, mem_address_i);
                error_count_o <= error_count_o + 1;
            end
            if (compare_i && sentinel_data != expected_i) begin
                $display("FAILED at %0t: sentinel expected %h, actual %h",
                         $time, expected_i, sentinel_data);
                error_count_o <= error_count_o + 1;
            end
        end
    end

endmodule

// ==== bench/tb_core.sv ====
// Testbench for the RV32I core
// Runs a table of small programs, each ending with a store to the sentinel word

`timescale 1ns/10ps

module tb_core;

    localparam int              N_PROGS   = 6;
    localparam int              N_WORDS   = 12;
    localparam int              TIMEOUT   = 400;
    localparam core_pkg::xlen_t RESET_PC  = 32'h0000_0000;
    localparam logic [31:0]     NOP       = 32'h0000_0013;

    logic                  clk;
    logic                  rst_n_i;
    logic                  stall_i;
    core_pkg::xlen_t       instruction_i;
    core_pkg::xlen_t       mem_data_i;
    core_pkg::xlen_t       instruction_address_o;
    core_pkg::xlen_t       mem_address_o;
    core_pkg::xlen_t       mem_data_o;
    core_pkg::byte_en_t    mem_write_enable_o;
    logic                  mem_operation_enable_o;

    logic                  compare;
    core_pkg::xlen_t       expected;
    logic                  sentinel_seen;
    int                    error_count;
    int                    timeouts;

    logic [31:0] rom [64];
    logic [31:0] ram [64];

    //////////////////////////////
    // Program table
    //////////////////////////////

    // 0 ALU chain, 1 dependent chain with load-use, 2 same chain padded with NOPs,
    // 3 byte and halfword stores and loads, 4 branches and jumps, 5 chain under stalls
    logic [31:0] prog_words [N_PROGS][N_WORDS] = '{
        '{32'hFF900093, 32'h00300113, 32'h402081B3, 32'h4021D233,
          32'h002222B3, 32'h00411313, 32'h006243B3, 32'h12345437,
          32'h007282B3, 32'h008282B3, 32'h10502023, 32'h0000006F},
        '{32'h00500093, 32'h00108133, 32'h00202423, 32'h00802183,
          32'h00218233, 32'h401202B3, 32'h00229293, 32'h10502023,
          32'h0000006F, NOP,          NOP,          NOP},
        '{32'h00500093, NOP,          32'h00108133, NOP,
          32'h00202423, 32'h00802183, NOP,          32'h00218233,
          32'h401202B3, 32'h00229293, 32'h10502023, 32'h0000006F},
        '{32'hF8000093, 32'h101000A3, 32'hEEF00113, 32'h10201123,
          32'h10100183, 32'h10104203, 32'h10201283, 32'h0041C333,
          32'h005303B3, 32'h10702023, 32'h0000006F, NOP},
        '{32'h00100093, 32'h00100113, 32'h00208463, 32'h06408093,
          32'h010001EF, 32'h00208093, 32'h10102023, 32'h0000006F,
          32'h01008093, 32'h00018067, 32'h06408093, NOP},
        '{32'h00500093, 32'h00108133, 32'h00202423, 32'h00802183,
          32'h00218233, 32'h401202B3, 32'h00229293, 32'h10502023,
          32'h0000006F, NOP,          NOP,          NOP}
    };
    logic        stall_flags    [N_PROGS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    logic [31:0] expected_words [N_PROGS] = '{
        32'h12344FCF, 32'h0000003C, 32'h0000003C,
        32'hFFFFFDEF, 32'h00000013, 32'h0000003C
    };

    rv_core #(
        .RESET_PC (RESET_PC)
    ) u_rv_core (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .mem_data_i             (mem_data_i),
        .instruction_address_o  (instruction_address_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_operation_enable_o (mem_operation_enable_o)
    );

    core_checker #(
        .RESET_PC (RESET_PC)
    ) u_checker (
        .clk                      (clk),
        .rst_n_i                  (rst_n_i),
        .instruction_address_i    (instruction_address_o),
        .mem_address_i            (mem_address_o),
        .mem_data_i               (mem_data_o),
        .mem_write_enable_i       (mem_write_enable_o),
        .mem_operation_enable_i   (mem_operation_enable_o),
        .compare_i                (compare),
        .expected_i               (expected),
        .sentinel_seen_o          (sentinel_seen),
        .error_count_o            (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // Memory models
    //////////////////////////////

    // Request sampled at the edge, answer driven shortly after
    core_pkg::xlen_t    i_addr, d_addr, d_wdata;
    core_pkg::byte_en_t d_we;
    logic               d_en;

    always @(posedge clk) begin
        i_addr  = instruction_address_o;
        d_addr  = mem_address_o;
        d_wdata = mem_data_o;
        d_we    = mem_write_enable_o;
        d_en    = mem_operation_enable_o;
        #2;
        instruction_i = rom[i_addr[7:2]];
        if (d_en) begin
            mem_data_i = ram[d_addr[7:2]];
            for (int b = 0; b < 4; b++) begin
                if (d_we[b]) begin
                    ram[d_addr[7:2]][8*b +: 8] = d_wdata[8*b +: 8];
                end
            end
        end
    end

    // ROM gets the program, NOP elsewhere; RAM gets an address-based fill
    task automatic load_program(input int p);
        for (int i = 0; i < 64; i++) begin
            rom[i] = (i < N_WORDS) ? prog_words[p][i] : NOP;
            ram[i] = {8'(i), 8'(i ^ 8'h5a), 8'(~i), 8'(i + 3)};
        end
    endtask

    task automatic reset_core();
        @(posedge clk);
        #2;
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int cycles;
        rst_n_i       = 1'b1;
        stall_i       = 1'b0;
        instruction_i = NOP;
        mem_data_i    = '0;
        compare       = 1'b0;
        expected      = '0;
        timeouts      = 0;
        void'($urandom(32'h8ef));

        for (int p = 0; p < N_PROGS; p++) begin
            load_program(p);
            reset_core();
            cycles = 0;
            // Run until the sentinel store shows up
            while (!sentinel_seen && cycles < TIMEOUT) begin
                @(posedge clk);
                #2;
                stall_i = stall_flags[p] && ($urandom % 100 < 30);
                cycles++;
            end
            stall_i = 1'b0;
            if (!sentinel_seen) begin
                $display("Timeout: program %0d never stored to the sentinel word in %0d cycles",
                         p, TIMEOUT);
                timeouts++;
            end else begin
                expected = expected_words[p];
                compare  = 1'b1;
                @(posedge clk);
                #2;
                compare  = 1'b0;
            end
        end

        @(posedge clk);
        $display("Summary: %0d programs, %0d check errors, %0d timeouts",
                 N_PROGS, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== hdl/core_pkg.sv ====
// Shared definitions for the three-stage RV32I core
// Widths, operation encoding and the structs passed between stages

package core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;

    // Major opcodes, instruction bits [6:0]
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;

    // NOP stays at zero so a cleared register decodes as idle
    typedef enum logic [4:0] {
        IOP_NOP, IOP_ADD, IOP_SUB, IOP_AND, IOP_OR, IOP_XOR,
        IOP_SLT, IOP_SLTU, IOP_SLL, IOP_SRL, IOP_SRA,
        IOP_LB, IOP_LBU, IOP_LH, IOP_LHU, IOP_LW,
        IOP_SB, IOP_SH, IOP_SW,
        IOP_BEQ, IOP_BNE, IOP_BLT, IOP_BGE,
        IOP_JAL, IOP_JALR
    } iop_e;

    // Decode to execute
    // rs1/rs2 are zero when the operand is not taken from a register
    typedef struct packed {
        iop_e      iop;
        xlen_t     pc;
        xlen_t     op_a;
        xlen_t     op_b;
        xlen_t     store_data;
        xlen_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      valid;
    } decode_out_t;

    // Execute to retire
    typedef struct packed {
        iop_e      iop;
        xlen_t     result;
        logic [1:0] addr_low;
        reg_addr_t rd;
        logic      write_enable;
    } retire_in_t;

    // Register bank write port
    typedef struct packed {
        reg_addr_t rd;
        xlen_t     data;
        logic      write_enable;
    } wb_t;

    function automatic logic is_load(iop_e op);
        return op inside {IOP_LB, IOP_LBU, IOP_LH, IOP_LHU, IOP_LW};
    endfunction

    function automatic logic is_store(iop_e op);
        return op inside {IOP_SB, IOP_SH, IOP_SW};
    endfunction

endpackage

// ==== hdl/decode_unit.sv ====
// Decode stage
// Field extraction, operand selection, load-use detection
// and the decode-to-execute register

`timescale 1ns/10ps

module decode_unit (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  jump_i,
    input  core_pkg::xlen_t       instruction_i,
    input  core_pkg::xlen_t       fetch_pc_i,
    input  logic                  fetch_valid_i,
    input  core_pkg::xlen_t       rs1_data_i,
    input  core_pkg::xlen_t       rs2_data_i,
    output core_pkg::reg_addr_t   rs1_o,
    output core_pkg::reg_addr_t   rs2_o,
    output logic                  hazard_o,
    output core_pkg::decode_out_t decode_o
);

    function automatic core_pkg::iop_e alu_op(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? core_pkg::IOP_SUB : core_pkg::IOP_ADD;
            3'b001:  return core_pkg::IOP_SLL;
            3'b010:  return core_pkg::IOP_SLT;
            3'b011:  return core_pkg::IOP_SLTU;
            3'b100:  return core_pkg::IOP_XOR;
            3'b101:  return alt ? core_pkg::IOP_SRA : core_pkg::IOP_SRL;
            3'b110:  return core_pkg::IOP_OR;
            default: return core_pkg::IOP_AND;
        endcase
    endfunction

    core_pkg::xlen_t held_instr;
    core_pkg::xlen_t instr;
    logic            use_hold;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    core_pkg::xlen_t imm_i, imm_s, imm_b, imm_u, imm_j;
    core_pkg::iop_e  iop;
    core_pkg::xlen_t op_a, op_b, imm;
    logic            use_rs1, use_rs2, writes_rd;

    //////////////////////////////
    // Replay of the frozen word
    //////////////////////////////

    // Memory moves on while decode is held, so keep the word seen first
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            use_hold <= 1'b0;
        end else begin
            use_hold <= stall_i || hazard_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!use_hold) begin
            held_instr <= instruction_i;
        end
    end

    assign instr  = use_hold ? held_instr : instruction_i;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    //////////////////////////////
    // Operation and operands
    //////////////////////////////

    always_comb begin
        iop       = core_pkg::IOP_NOP;
        op_a      = rs1_data_i;
        op_b      = rs2_data_i;
        imm       = imm_b;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        writes_rd = 1'b1;
        case (opcode)
            core_pkg::OPCODE_OP: begin
                iop     = alu_op(funct3, instr[30]);
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            core_pkg::OPCODE_OP_IMM: begin
                // Only SRAI uses bit 30, ADDI never subtracts
                iop     = alu_op(funct3, funct3 == 3'b101 && instr[30]);
                op_b    = imm_i;
                use_rs1 = 1'b1;
            end
            core_pkg::OPCODE_LUI: begin
                iop  = core_pkg::IOP_ADD;
                op_a = '0;
                op_b = imm_u;
            end
            core_pkg::OPCODE_AUIPC: begin
                iop  = core_pkg::IOP_ADD;
                op_a = fetch_pc_i;
                op_b = imm_u;
            end
            core_pkg::OPCODE_LOAD: begin
                case (funct3)
                    3'b000:  iop = core_pkg::IOP_LB;
                    3'b001:  iop = core_pkg::IOP_LH;
                    3'b010:  iop = core_pkg::IOP_LW;
                    3'b100:  iop = core_pkg::IOP_LBU;
                    3'b101:  iop = core_pkg::IOP_LHU;
                    default: iop = core_pkg::IOP_NOP;
                endcase
                op_b    = imm_i;
                use_rs1 = 1'b1;
            end
            core_pkg::OPCODE_STORE: begin
                case (funct3)
                    3'b000:  iop = core_pkg::IOP_SB;
                    3'b001:  iop = core_pkg::IOP_SH;
                    3'b010:  iop = core_pkg::IOP_SW;
                    default: iop = core_pkg::IOP_NOP;
                endcase
                op_b      = imm_s;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                writes_rd = 1'b0;
            end
            core_pkg::OPCODE_BRANCH: begin
                case (funct3)
                    3'b000:  iop = core_pkg::IOP_BEQ;
                    3'b001:  iop = core_pkg::IOP_BNE;
                    3'b100:  iop = core_pkg::IOP_BLT;
                    3'b101:  iop = core_pkg::IOP_BGE;
                    default: iop = core_pkg::IOP_NOP;
                endcase
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                writes_rd = 1'b0;
            end
            core_pkg::OPCODE_JAL: begin
                iop = core_pkg::IOP_JAL;
                imm = imm_j;
            end
            core_pkg::OPCODE_JALR: begin
                iop     = core_pkg::IOP_JALR;
                op_b    = imm_i;
                use_rs1 = 1'b1;
            end
            default: begin
                iop = core_pkg::IOP_NOP;
            end
        endcase
    end

    // Load in execute feeding this instruction, data not back yet
    assign hazard_o = fetch_valid_i && decode_o.valid && core_pkg::is_load(decode_o.iop)
                      && decode_o.rd != '0
                      && ((use_rs1 && rs1_o == decode_o.rd) || (use_rs2 && rs2_o == decode_o.rd));

    //////////////////////////////
    // Decode to execute register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            decode_o <= '0;
        end else if (!stall_i) begin
            // Bubble on redirect, load-use or empty fetch slot
            decode_o.valid      <= fetch_valid_i && !jump_i && !hazard_o;
            decode_o.iop        <= iop;
            decode_o.pc         <= fetch_pc_i;
            decode_o.op_a       <= op_a;
            decode_o.op_b       <= op_b;
            decode_o.store_data <= rs2_data_i;
            decode_o.imm        <= imm;
            decode_o.rs1        <= use_rs1 ? rs1_o : '0;
            decode_o.rs2        <= use_rs2 ? rs2_o : '0;
            decode_o.rd         <= (writes_rd && iop != core_pkg::IOP_NOP) ? instr[11:7] : '0;
        end
    end

    // The bubble clears the load, so the stall never repeats
    assert property (@(posedge clk) disable iff (!rst_n_i)
        hazard_o && !stall_i |=> !hazard_o);

endmodule

// ==== hdl/execute_unit.sv ====
// Execute stage
// ALU, branch resolution, data memory request and the execute-to-retire register

`timescale 1ns/10ps

module execute_unit (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  core_pkg::decode_out_t decode_i,
    input  core_pkg::wb_t         wb_i,
    output logic                  jump_o,
    output core_pkg::xlen_t       jump_target_o,
    output core_pkg::xlen_t       mem_address_o,
    output core_pkg::byte_en_t    mem_write_enable_o,
    output core_pkg::xlen_t       mem_data_o,
    output logic                  mem_operation_enable_o,
    output core_pkg::retire_in_t  retire_o
);

    core_pkg::xlen_t   op_a, op_b, st_data;
    core_pkg::xlen_t   sum, alu_result;
    core_pkg::byte_en_t lanes;
    logic              fwd_rs1, fwd_rs2;
    logic              taken;

    //////////////////////////////
    // Writeback forwarding
    //////////////////////////////

    // Unused operands carry rs = x0, which never matches a write
    assign fwd_rs1 = wb_i.write_enable && wb_i.rd == decode_i.rs1;
    assign fwd_rs2 = wb_i.write_enable && wb_i.rd == decode_i.rs2;

    assign op_a    = fwd_rs1 ? wb_i.data : decode_i.op_a;
    // Stores keep the offset in op_b, rs2 is the data
    assign op_b    = (fwd_rs2 && !core_pkg::is_store(decode_i.iop)) ? wb_i.data : decode_i.op_b;
    assign st_data = fwd_rs2 ? wb_i.data : decode_i.store_data;

    assign sum = op_a + op_b;

    always_comb begin
        taken = 1'b0;
        case (decode_i.iop)
            core_pkg::IOP_SUB:  alu_result = op_a - op_b;
            core_pkg::IOP_AND:  alu_result = op_a & op_b;
            core_pkg::IOP_OR:   alu_result = op_a | op_b;
            core_pkg::IOP_XOR:  alu_result = op_a ^ op_b;
            core_pkg::IOP_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::IOP_SLTU: alu_result = {31'b0, op_a < op_b};
            core_pkg::IOP_SLL:  alu_result = op_a << op_b[4:0];
            core_pkg::IOP_SRL:  alu_result = op_a >> op_b[4:0];
            core_pkg::IOP_SRA:  alu_result = core_pkg::xlen_t'($signed(op_a) >>> op_b[4:0]);
            core_pkg::IOP_JAL, core_pkg::IOP_JALR: begin
                // Link value
                alu_result = decode_i.pc + 32'd4;
                taken      = 1'b1;
            end
            default:            alu_result = sum;
        endcase
        case (decode_i.iop)
            core_pkg::IOP_BEQ: taken = op_a == op_b;
            core_pkg::IOP_BNE: taken = op_a != op_b;
            core_pkg::IOP_BLT: taken = $signed(op_a) < $signed(op_b);
            core_pkg::IOP_BGE: taken = $signed(op_a) >= $signed(op_b);
            default: ;
        endcase
    end

    assign jump_o        = decode_i.valid && taken;
    assign jump_target_o = (decode_i.iop == core_pkg::IOP_JALR) ? {sum[31:1], 1'b0}
                                                                : decode_i.pc + decode_i.imm;

    //////////////////////////////
    // Data memory request
    //////////////////////////////

    always_comb begin
        case (decode_i.iop)
            core_pkg::IOP_SB: lanes = 4'b0001 << sum[1:0];
            core_pkg::IOP_SH: lanes = 4'b0011 << sum[1:0];
            core_pkg::IOP_SW: lanes = 4'b1111;
            default:          lanes = 4'b0000;
        endcase
    end

    assign mem_address_o          = sum;
    assign mem_data_o             = st_data << {sum[1:0], 3'b000};
    assign mem_write_enable_o     = decode_i.valid ? lanes : 4'b0000;
    assign mem_operation_enable_o = decode_i.valid
                                    && (core_pkg::is_load(decode_i.iop)
                                        || core_pkg::is_store(decode_i.iop));

    //////////////////////////////
    // Execute to retire register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_o <= '0;
        end else if (stall_i) begin
            // Pin the resolved value, load data is gone after this cycle
            retire_o.result <= wb_i.data;
            retire_o.iop    <= core_pkg::IOP_NOP;
        end else begin
            retire_o.iop          <= decode_i.iop;
            retire_o.result       <= alu_result;
            retire_o.addr_low     <= sum[1:0];
            retire_o.rd           <= decode_i.rd;
            retire_o.write_enable <= decode_i.valid && decode_i.rd != '0;
        end
    end

    // Held request stays on the bus unchanged across a stall
    assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i && mem_operation_enable_o |=> mem_operation_enable_o
        && $stable(mem_address_o) && $stable(mem_data_o) && $stable(mem_write_enable_o));

endmodule

// ==== hdl/fetch_unit.sv ====
// Fetch stage
// Holds the PC and tracks the word in flight from the instruction memory

`timescale 1ns/10ps

module fetch_unit #(
    parameter core_pkg::xlen_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            hazard_i,
    input  logic            jump_i,
    input  core_pkg::xlen_t jump_target_i,
    output core_pkg::xlen_t instruction_address_o,
    output core_pkg::xlen_t fetch_pc_o,
    output logic            fetch_valid_o
);

    core_pkg::xlen_t pc;
    core_pkg::xlen_t next_pc;

    // Redirect wins over sequential flow
    assign next_pc = jump_i ? jump_target_i : pc + 32'd4;
    assign instruction_address_o = pc;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc            <= RESET_PC;
            fetch_pc_o    <= RESET_PC;
            fetch_valid_o <= 1'b0;
        end else if (!stall_i) begin
            if (jump_i) begin
                // Word already requested is on the wrong path
                pc            <= next_pc;
                fetch_valid_o <= 1'b0;
            end else if (!hazard_i) begin
                pc            <= next_pc;
                fetch_pc_o    <= pc;
                fetch_valid_o <= 1'b1;
            end
        end
    end

    // Address frozen across a stall
    assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable(instruction_address_o));

endmodule

// ==== hdl/reg_bank.sv ====
// Integer register bank
// 31 flip-flop registers, two read ports, same-cycle writeback bypass

`timescale 1ns/10ps

module reg_bank (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::reg_addr_t rs1_i,
    input  core_pkg::reg_addr_t rs2_i,
    input  core_pkg::wb_t       wb_i,
    output core_pkg::xlen_t     rs1_data_o,
    output core_pkg::xlen_t     rs2_data_o
);

    // x0 has no storage
    core_pkg::xlen_t regs [31:1];
    logic            wr_en;

    assign wr_en = wb_i.write_enable && wb_i.rd != '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Reads see a write landing this cycle
    assign rs1_data_o = (rs1_i == '0)                 ? '0 :
                        (wr_en && wb_i.rd == rs1_i)    ? wb_i.data : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0)                 ? '0 :
                        (wr_en && wb_i.rd == rs2_i)    ? wb_i.data : regs[rs2_i];

endmodule

// ==== hdl/retire_unit.sv ====
// Retire step
// Aligns and extends load data, then forms the register writeback

`timescale 1ns/10ps

module retire_unit (
    input  core_pkg::retire_in_t retire_i,
    input  core_pkg::xlen_t      mem_data_i,
    output core_pkg::wb_t        wb_o
);

    core_pkg::xlen_t shifted;

    // Addressed byte or halfword moved down to bit 0
    assign shifted = mem_data_i >> {retire_i.addr_low, 3'b000};

    always_comb begin
        case (retire_i.iop)
            core_pkg::IOP_LB:  wb_o.data = {{24{shifted[7]}}, shifted[7:0]};
            core_pkg::IOP_LBU: wb_o.data = {24'b0, shifted[7:0]};
            core_pkg::IOP_LH:  wb_o.data = {{16{shifted[15]}}, shifted[15:0]};
            core_pkg::IOP_LHU: wb_o.data = {16'b0, shifted[15:0]};
            core_pkg::IOP_LW:  wb_o.data = mem_data_i;
            default:           wb_o.data = retire_i.result;
        endcase
    end

    assign wb_o.rd           = retire_i.rd;
    // x0 and empty slots never write
    assign wb_o.write_enable = retire_i.write_enable && retire_i.rd != '0;

endmodule

// ==== hdl/rv_core.sv ====
// RV32I core top level
// Fetch, decode, execute and retire with the register bank beside decode

`timescale 1ns/10ps

module rv_core #(
    parameter core_pkg::xlen_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               stall_i,
    input  core_pkg::xlen_t    instruction_i,
    input  core_pkg::xlen_t    mem_data_i,
    output core_pkg::xlen_t    instruction_address_o,
    output core_pkg::xlen_t    mem_address_o,
    output core_pkg::xlen_t    mem_data_o,
    output core_pkg::byte_en_t mem_write_enable_o,
    output logic               mem_operation_enable_o
);

    //////////////////////////////
    // Stage links
    //////////////////////////////

    logic                  jump;
    logic                  hazard;
    logic                  fetch_valid;
    core_pkg::xlen_t       jump_target;
    core_pkg::xlen_t       fetch_pc;
    core_pkg::reg_addr_t   rs1, rs2;
    core_pkg::xlen_t       rs1_data, rs2_data;
    core_pkg::decode_out_t decode_out;
    core_pkg::retire_in_t  retire_in;
    core_pkg::wb_t         wb;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .stall_i               (stall_i),
        .hazard_i              (hazard),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .fetch_pc_o            (fetch_pc),
        .fetch_valid_o         (fetch_valid)
    );

    decode_unit u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .jump_i        (jump),
        .instruction_i (instruction_i),
        .fetch_pc_i    (fetch_pc),
        .fetch_valid_i (fetch_valid),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .hazard_o      (hazard),
        .decode_o      (decode_out)
    );

    reg_bank u_reg_bank (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute_unit u_execute (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .stall_i                (stall_i),
        .decode_i               (decode_out),
        .wb_i                   (wb),
        .jump_o                 (jump),
        .jump_target_o          (jump_target),
        .mem_address_o          (mem_address_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_data_o             (mem_data_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .retire_o               (retire_in)
    );

    retire_unit u_retire (
        .retire_i   (retire_in),
        .mem_data_i (mem_data_i),
        .wb_o       (wb)
    );

endmodule

// ==== tb.f ====
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_bank.sv
hdl/execute_unit.sv
hdl/retire_unit.sv
hdl/rv_core.sv
bench/core_checker.sv
bench/tb_core.sv
